// File: Makefile
BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_mem_to_cache \
	  -f vlog.f --Mdir $(BUILD_DIR) -o tb_mem_to_cache
	./$(BUILD_DIR)/tb_mem_to_cache

clean:
	rm -rf $(BUILD_DIR)

// File: cache_req_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cache_req_if;

  import mem_cache_pkg::*;

  cache_opcode_e opcode;
  addr_t         addr;
  data_t         data;
  mask_t         mask;
  logic          v;
  // transfer when v and ready are both high
  logic          ready;

  modport src
    (output opcode, addr, data, mask, v
    , input ready
    );

  modport dst
    (input opcode, addr, data, mask, v
    , output ready
    );

endinterface

`default_nettype wire

// File: cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decode
  (input  mem_cache_pkg::mem_hdr_s mem_cmd_hdr_i
  , input  mem_cache_pkg::data_t    mem_cmd_data_i
  , input  logic                    mem_cmd_v_i
  , output logic                    mem_cmd_ready_and_o
  , input  logic                    init_pkt_v_i
  , input  mem_cache_pkg::addr_t    init_pkt_addr_i
  , output logic                    init_pkt_ready_o
  , input  logic                    init_done_i
  , output logic                    hdr_push_o
  , input  logic                    hdr_full_i
  , cache_req_if.src                cache_req
  );

  import mem_cache_pkg::*;

  cache_opcode_e cmd_opcode;
  mask_t         cmd_mask;
  data_t         cmd_data;
  logic          cmd_pkt_v;

  // loads always use the zero-extending opcodes
  always_comb
  begin
    if (mem_cmd_hdr_i.msg_type == e_mem_wr)
    begin
      case (mem_cmd_hdr_i.size)
        e_size_1: cmd_opcode = SB;
        e_size_2: cmd_opcode = SH;
        e_size_4: cmd_opcode = SW;
        default:  cmd_opcode = SD;
      endcase
    end
    else
    begin
      case (mem_cmd_hdr_i.size)
        e_size_1: cmd_opcode = LBU;
        e_size_2: cmd_opcode = LHU;
        e_size_4: cmd_opcode = LWU;
        default:  cmd_opcode = LD;
      endcase
    end
  end

  // byte lanes touched by the access, size aligned
  always_comb
  begin
    case (mem_cmd_hdr_i.size)
      e_size_1: cmd_mask = 8'h01 << mem_cmd_hdr_i.addr[2:0];
      e_size_2: cmd_mask = 8'h03 << {mem_cmd_hdr_i.addr[2:1], 1'b0};
      e_size_4: cmd_mask = 8'h0f << {mem_cmd_hdr_i.addr[2], 2'b00};
      default:  cmd_mask = '1;
    endcase
  end

  // write data lands in whichever lane the mask picks
  assign cmd_data = replicate_slice(mem_cmd_data_i, mem_cmd_hdr_i.size);

  // a packet needs a free header slot, independent of ready
  assign cmd_pkt_v           = mem_cmd_v_i & init_done_i & ~hdr_full_i;
  assign mem_cmd_ready_and_o = init_done_i & ~hdr_full_i & cache_req.ready;
  assign hdr_push_o          = mem_cmd_v_i & mem_cmd_ready_and_o;
  assign init_pkt_ready_o    = ~init_done_i & cache_req.ready;

  always_comb
  begin
    if (init_done_i)
    begin
      cache_req.opcode = cmd_opcode;
      cache_req.addr   = mem_cmd_hdr_i.addr;
      cache_req.data   = cmd_data;
      cache_req.mask   = cmd_mask;
      cache_req.v      = cmd_pkt_v;
    end
    else
    begin
      // tag clear phase, stores of zero tags
      cache_req.opcode = TAGST;
      cache_req.addr   = init_pkt_addr_i;
      cache_req.data   = '0;
      cache_req.mask   = '0;
      cache_req.v      = init_pkt_v_i;
    end
  end

endmodule

`default_nettype wire

// File: mem_cache_pkg.sv
`default_nettype none

package mem_cache_pkg;

  // data path
  localparam int data_width_c = 64;
  localparam int data_bytes_c = data_width_c / 8;
  localparam int addr_width_c = 32;

  // cache geometry, single bank with 32-byte blocks
  localparam int sets_c = 16;
  localparam int assoc_c = 2;
  localparam int block_offset_width_c = 5;
  localparam int tag_blocks_c = sets_c * assoc_c;
  localparam int tag_index_width_c = $clog2(tag_blocks_c);
  localparam int init_cnt_width_c = tag_index_width_c + 1;

  // header queue
  localparam int hdr_fifo_depth_c = 4;
  localparam int hdr_ptr_width_c = $clog2(hdr_fifo_depth_c);
  localparam int hdr_cnt_width_c = hdr_ptr_width_c + 1;

  typedef logic [data_width_c-1:0] data_t;
  typedef logic [data_bytes_c-1:0] mask_t;
  typedef logic [addr_width_c-1:0] addr_t;

  typedef enum logic {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } msg_type_e;

  // log2 of the access size in bytes
  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  // codes match the cache's own opcode table
  typedef enum logic [4:0] {
    LD    = 5'd3,
    LBU   = 5'd4,
    LHU   = 5'd5,
    LWU   = 5'd6,
    SB    = 5'd8,
    SH    = 5'd9,
    SW    = 5'd10,
    SD    = 5'd11,
    TAGST = 5'd16
  } cache_opcode_e;

  typedef struct packed {
    msg_type_e msg_type;
    msg_size_e size;
    addr_t     addr;
  } mem_hdr_s;

  // copy the low slice of the given size into every lane of the word
  function automatic data_t replicate_slice(data_t d, msg_size_e size);
    data_t r;
    case (size)
      e_size_1: r = {(data_width_c/8){d[7:0]}};
      e_size_2: r = {(data_width_c/16){d[15:0]}};
      e_size_4: r = {(data_width_c/32){d[31:0]}};
      default:  r = d;
    endcase
    return r;
  endfunction

endpackage

`default_nettype wire

// File: mem_to_cache.sv
`timescale 1ns/1ns
`default_nettype none

module mem_to_cache
  (input  logic                         clk_i
  , input  logic                         reset_i
  , input  mem_cache_pkg::msg_type_e     mem_cmd_type_i
  , input  mem_cache_pkg::msg_size_e     mem_cmd_size_i
  , input  mem_cache_pkg::addr_t         mem_cmd_addr_i
  , input  mem_cache_pkg::data_t         mem_cmd_data_i
  , input  logic                         mem_cmd_v_i
  , output logic                         mem_cmd_ready_and_o
  , output mem_cache_pkg::msg_type_e     mem_resp_type_o
  , output mem_cache_pkg::msg_size_e     mem_resp_size_o
  , output mem_cache_pkg::addr_t         mem_resp_addr_o
  , output mem_cache_pkg::data_t         mem_resp_data_o
  , output logic                         mem_resp_v_o
  , input  logic                         mem_resp_ready_and_i
  , output mem_cache_pkg::cache_opcode_e cache_pkt_opcode_o
  , output mem_cache_pkg::addr_t         cache_pkt_addr_o
  , output mem_cache_pkg::data_t         cache_pkt_data_o
  , output mem_cache_pkg::mask_t         cache_pkt_mask_o
  , output logic                         cache_pkt_v_o
  , input  logic                         cache_pkt_ready_and_i
  , input  mem_cache_pkg::data_t         cache_data_i
  , input  logic                         cache_data_v_i
  , output logic                         cache_data_yumi_o
  );

  import mem_cache_pkg::*;

  mem_hdr_s cmd_hdr;
  mem_hdr_s resp_hdr;
  addr_t    init_pkt_addr;
  logic     init_pkt_v;
  logic     init_pkt_ready;
  logic     init_ack;
  logic     init_done;
  logic     hdr_push;
  logic     hdr_full;

  cache_req_if cache_req ();
  resp_hdr_if  hdr_q ();

  assign cmd_hdr = '{msg_type: mem_cmd_type_i, size: mem_cmd_size_i, addr: mem_cmd_addr_i};

  assign mem_resp_type_o = resp_hdr.msg_type;
  assign mem_resp_size_o = resp_hdr.size;
  assign mem_resp_addr_o = resp_hdr.addr;

  // cache request out to plain ports
  assign cache_pkt_opcode_o = cache_req.opcode;
  assign cache_pkt_addr_o   = cache_req.addr;
  assign cache_pkt_data_o   = cache_req.data;
  assign cache_pkt_mask_o   = cache_req.mask;
  assign cache_pkt_v_o      = cache_req.v;
  assign cache_req.ready    = cache_pkt_ready_and_i;

  tag_init_seq i_tag_init
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .init_pkt_v_o(init_pkt_v)
    , .init_pkt_addr_o(init_pkt_addr)
    , .init_pkt_ready_i(init_pkt_ready)
    , .init_ack_i(init_ack)
    , .init_done_o(init_done)
    );

  cmd_decode i_cmd_decode
    (.mem_cmd_hdr_i(cmd_hdr)
    , .mem_cmd_data_i(mem_cmd_data_i)
    , .mem_cmd_v_i(mem_cmd_v_i)
    , .mem_cmd_ready_and_o(mem_cmd_ready_and_o)
    , .init_pkt_v_i(init_pkt_v)
    , .init_pkt_addr_i(init_pkt_addr)
    , .init_pkt_ready_o(init_pkt_ready)
    , .init_done_i(init_done)
    , .hdr_push_o(hdr_push)
    , .hdr_full_i(hdr_full)
    , .cache_req(cache_req.src)
    );

  resp_hdr_fifo i_hdr_fifo
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .push_i(hdr_push)
    , .hdr_i(cmd_hdr)
    , .full_o(hdr_full)
    , .q(hdr_q.prod)
    );

  resp_pack i_resp_pack
    (.q(hdr_q.cons)
    , .init_done_i(init_done)
    , .cache_data_i(cache_data_i)
    , .cache_data_v_i(cache_data_v_i)
    , .cache_data_yumi_o(cache_data_yumi_o)
    , .init_ack_o(init_ack)
    , .mem_resp_hdr_o(resp_hdr)
    , .mem_resp_data_o(mem_resp_data_o)
    , .mem_resp_v_o(mem_resp_v_o)
    , .mem_resp_ready_and_i(mem_resp_ready_and_i)
    );

endmodule

`default_nettype wire

// File: resp_hdr_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module resp_hdr_fifo
  (input  logic                    clk_i
  , input  logic                    reset_i
  , input  logic                    push_i
  , input  mem_cache_pkg::mem_hdr_s hdr_i
  , output logic                    full_o
  , resp_hdr_if.prod                q
  );

  import mem_cache_pkg::*;

  mem_hdr_s mem_r [hdr_fifo_depth_c];
  logic [hdr_ptr_width_c-1:0] wr_ptr_r;
  logic [hdr_ptr_width_c-1:0] rd_ptr_r;
  logic [hdr_cnt_width_c-1:0] count_r;
  logic pop;

  assign pop    = q.yumi;
  assign full_o = (count_r == hdr_cnt_width_c'(hdr_fifo_depth_c));
  assign q.v    = (count_r != '0);
  assign q.hdr  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_r[wr_ptr_r] <= hdr_i;
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({push_i, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: resp_hdr_if.sv
`timescale 1ns/1ns
`default_nettype none

interface resp_hdr_if;

  import mem_cache_pkg::*;

  // head of the queue
  mem_hdr_s hdr;
  logic     v;
  // pops the head, only while v is high
  logic     yumi;

  modport prod
    (output hdr, v
    , input yumi
    );

  modport cons
    (input hdr, v
    , output yumi
    );

endinterface

`default_nettype wire

// File: resp_pack.sv
`timescale 1ns/1ns
`default_nettype none

module resp_pack
  (resp_hdr_if.cons                 q
  , input  logic                    init_done_i
  , input  mem_cache_pkg::data_t    cache_data_i
  , input  logic                    cache_data_v_i
  , output logic                    cache_data_yumi_o
  , output logic                    init_ack_o
  , output mem_cache_pkg::mem_hdr_s mem_resp_hdr_o
  , output mem_cache_pkg::data_t    mem_resp_data_o
  , output logic                    mem_resp_v_o
  , input  logic                    mem_resp_ready_and_i
  );

  import mem_cache_pkg::*;

  logic resp_fire;

  // during tag clear every beat is an ack and never a response
  assign init_ack_o = ~init_done_i & cache_data_v_i;

  // cache answers in order, so the head header owns the beat
  assign mem_resp_v_o = init_done_i & q.v & cache_data_v_i;
  assign resp_fire    = mem_resp_v_o & mem_resp_ready_and_i;
  assign q.yumi       = resp_fire;

  assign cache_data_yumi_o = init_ack_o | resp_fire;

  assign mem_resp_hdr_o = q.hdr;
  // loads come back lsb aligned, stores come back as zeros
  assign mem_resp_data_o = replicate_slice(cache_data_i, q.hdr.size);

endmodule

`default_nettype wire

// File: tag_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

module tag_init_seq
  (input  logic                  clk_i
  , input  logic                  reset_i
  , output logic                  init_pkt_v_o
  , output mem_cache_pkg::addr_t  init_pkt_addr_o
  , input  logic                  init_pkt_ready_i
  , input  logic                  init_ack_i
  , output logic                  init_done_o
  );

  import mem_cache_pkg::*;

  typedef enum logic [1:0] {e_reset, e_clear, e_ready} state_e;

  state_e state_r, state_n;
  logic [init_cnt_width_c-1:0] sent_r, sent_n;
  logic [init_cnt_width_c-1:0] acked_r, acked_n;
  logic all_sent;
  logic all_acked;

  assign all_sent  = (sent_r == init_cnt_width_c'(tag_blocks_c));
  assign all_acked = (acked_r == init_cnt_width_c'(tag_blocks_c));

  // one tag store per set and way, block aligned
  assign init_pkt_v_o    = (state_r == e_clear) & ~all_sent;
  assign init_pkt_addr_o = addr_t'(sent_r[tag_index_width_c-1:0]) << block_offset_width_c;
  assign init_done_o     = (state_r == e_ready);

  always_comb
  begin
    state_n = state_r;
    sent_n  = sent_r;
    acked_n = acked_r;
    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        if (init_pkt_v_o && init_pkt_ready_i)
          sent_n = sent_r + 1'b1;
        if (init_ack_i)
          acked_n = acked_r + 1'b1;
        // leave only once every store is out and answered
        if (all_sent && all_acked)
          state_n = e_ready;
      end
      default:
        state_n = state_r;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      sent_r  <= '0;
      acked_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      sent_r  <= sent_n;
      acked_r <= acked_n;
    end
  end

endmodule

`default_nettype wire

// File: tb_cache_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_model
  (input  logic                         clk_i
  , input  logic                         stall_i
  , input  mem_cache_pkg::cache_opcode_e pkt_opcode_i
  , input  mem_cache_pkg::addr_t         pkt_addr_i
  , input  mem_cache_pkg::data_t         pkt_data_i
  , input  mem_cache_pkg::mask_t         pkt_mask_i
  , input  logic                         pkt_v_i
  , output logic                         pkt_ready_o
  , output mem_cache_pkg::data_t         data_o
  , output logic                         data_v_o
  , input  logic                         data_yumi_i
  );

  import mem_cache_pkg::*;

  // 256 bytes, addresses alias on the low byte
  logic [7:0] mem [256];
  data_t      beat_q [$];
  addr_t      tag_log [2*tag_blocks_c];
  int         tag_cnt = 0;

  assign pkt_ready_o = ~stall_i;

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[8'(i)] = 8'(i * 29 + 7);
    data_o   = '0;
    data_v_o = 1'b0;
  end

  always @(posedge clk_i)
  begin
    data_t      beat;
    int         n;
    logic [7:0] base;
    if (data_yumi_i && beat_q.size() != 0)
      void'(beat_q.pop_front());
    if (pkt_v_i && pkt_ready_o)
    begin
      beat = '0;
      base = pkt_addr_i[7:0];
      case (pkt_opcode_i)
        LBU, LHU, LWU, LD:
        begin
          n = (pkt_opcode_i == LBU) ? 1 : (pkt_opcode_i == LHU) ? 2 :
              (pkt_opcode_i == LWU) ? 4 : 8;
          // lsb aligned, zero extended
          for (int i = 0; i < n; i++)
            beat[8*i +: 8] = mem[base + 8'(i)];
        end
        TAGST:
        begin
          if (tag_cnt < 2*tag_blocks_c)
            tag_log[tag_cnt[5:0]] <= pkt_addr_i;
          tag_cnt <= tag_cnt + 1;
        end
        // stores only touch the masked lanes of the aligned word
        default:
          for (int j = 0; j < data_bytes_c; j++)
            if (pkt_mask_i[j])
              mem[{base[7:3], 3'(j)}] = pkt_data_i[8*j +: 8];
      endcase
      beat_q.push_back(beat);
    end
  end

  // beats show up on the falling edge after the packet
  always @(negedge clk_i)
  begin
    data_v_o <= (beat_q.size() != 0);
    data_o   <= (beat_q.size() != 0) ? beat_q[0] : '0;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
  #(parameter int half_period_p = 5
  , parameter int reset_cycles_p = 16
  )
  (output logic clk_o
  , output logic reset_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #half_period_p clk_o = ~clk_o;
  end

  // reset is released on a falling edge so the DUT sees it cleanly
  initial
  begin
    reset_o = 1'b1;
    repeat (reset_cycles_p)
      @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_mem_to_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_to_cache;

  import mem_cache_pkg::*;

  // limit sits far above the length of all tests together
  localparam int max_cycles_c = 20000;
  localparam int random_cmds_c = 200;
  localparam logic [31:0] seed_c = 32'haf69_05d3;

  logic          clk;
  logic          reset;
  msg_type_e     cmd_type;
  msg_size_e     cmd_size;
  addr_t         cmd_addr;
  data_t         cmd_data;
  logic          cmd_v;
  logic          cmd_ready;
  msg_type_e     resp_type;
  msg_size_e     resp_size;
  addr_t         resp_addr;
  data_t         resp_data;
  logic          resp_v;
  logic          resp_ready;
  cache_opcode_e pkt_opcode;
  addr_t         pkt_addr;
  data_t         pkt_data;
  mask_t         pkt_mask;
  logic          pkt_v;
  logic          pkt_ready;
  data_t         cache_data;
  logic          cache_data_v;
  logic          cache_data_yumi;
  logic          cache_stall = 1'b0;

  logic [31:0] stall_lfsr = seed_c;
  logic [31:0] traffic_lfsr = seed_c;
  logic [7:0]  ref_mem [256];
  mem_hdr_s    exp_hdr_q [$];
  data_t       exp_data_q [$];
  int          cycles = 0;

  tb_clock_gen i_clk_gen
    (.clk_o(clk)
    , .reset_o(reset)
    );

  mem_to_cache i_dut
    (.clk_i(clk)
    , .reset_i(reset)
    , .mem_cmd_type_i(cmd_type)
    , .mem_cmd_size_i(cmd_size)
    , .mem_cmd_addr_i(cmd_addr)
    , .mem_cmd_data_i(cmd_data)
    , .mem_cmd_v_i(cmd_v)
    , .mem_cmd_ready_and_o(cmd_ready)
    , .mem_resp_type_o(resp_type)
    , .mem_resp_size_o(resp_size)
    , .mem_resp_addr_o(resp_addr)
    , .mem_resp_data_o(resp_data)
    , .mem_resp_v_o(resp_v)
    , .mem_resp_ready_and_i(resp_ready)
    , .cache_pkt_opcode_o(pkt_opcode)
    , .cache_pkt_addr_o(pkt_addr)
    , .cache_pkt_data_o(pkt_data)
    , .cache_pkt_mask_o(pkt_mask)
    , .cache_pkt_v_o(pkt_v)
    , .cache_pkt_ready_and_i(pkt_ready)
    , .cache_data_i(cache_data)
    , .cache_data_v_i(cache_data_v)
    , .cache_data_yumi_o(cache_data_yumi)
    );

  tb_cache_model i_cache
    (.clk_i(clk)
    , .stall_i(cache_stall)
    , .pkt_opcode_i(pkt_opcode)
    , .pkt_addr_i(pkt_addr)
    , .pkt_data_i(pkt_data)
    , .pkt_mask_i(pkt_mask)
    , .pkt_v_i(pkt_v)
    , .pkt_ready_o(pkt_ready)
    , .data_o(cache_data)
    , .data_v_o(cache_data_v)
    , .data_yumi_i(cache_data_yumi)
    );

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r[i] = traffic_lfsr[0];
      traffic_lfsr = lfsr_step(traffic_lfsr);
    end
    return r;
  endfunction

  // every byte lane carries byte (lane mod n) of the low slice
  function automatic data_t spread(data_t lo, int n);
    data_t r;
    for (int i = 0; i < data_bytes_c; i++)
      r[8*i +: 8] = lo[8*(i % n) +: 8];
    return r;
  endfunction

  function automatic mask_t lane_mask(addr_t a, int n);
    return mask_t'(((1 << n) - 1) << a[2:0]);
  endfunction

  function automatic cache_opcode_e expected_opcode(msg_type_e t, int n);
    if (t == e_mem_wr)
      return (n == 1) ? SB : (n == 2) ? SH : (n == 4) ? SW : SD;
    else
      return (n == 1) ? LBU : (n == 2) ? LHU : (n == 4) ? LWU : LD;
  endfunction

  task automatic stop_run(string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic data_check(data_t got, data_t exp, string what);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic mask_check(mask_t got, mask_t exp, string what);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic addr_check(addr_t got, addr_t exp, string what);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic opcode_check(cache_opcode_e got, cache_opcode_e exp, string what);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic hdr_check(mem_hdr_s got, mem_hdr_s exp, string what);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %0t: %s got type %0d size %0d addr %h, expected %0d %0d %h",
        $time, what, got.msg_type, got.size, got.addr, exp.msg_type, exp.size, exp.addr));
  endtask

  // offer one command and check the cache packet in its accept cycle
  task automatic drive_cmd(msg_type_e t, msg_size_e s, addr_t a, data_t d);
    int       n;
    data_t    loaded;
    mem_hdr_s exp_hdr;
    n = 1 << int'(s);
    loaded = '0;
    @(negedge clk);
    cmd_type = t;
    cmd_size = s;
    cmd_addr = a;
    cmd_data = d;
    cmd_v = 1'b1;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    if (pkt_v !== 1'b1)
      stop_run("cache packet was not valid in the cycle its command was accepted");
    opcode_check(pkt_opcode, expected_opcode(t, n), "packet opcode");
    addr_check(pkt_addr, a, "packet address");
    mask_check(pkt_mask, lane_mask(a, n), "packet mask");
    if (t == e_mem_wr)
      data_check(pkt_data, spread(d, n), "packet write data");
    for (int i = 0; i < n; i++)
    begin
      if (t == e_mem_wr)
        ref_mem[a[7:0] + 8'(i)] = d[8*i +: 8];
      else
        loaded[8*i +: 8] = ref_mem[a[7:0] + 8'(i)];
    end
    exp_hdr.msg_type = t;
    exp_hdr.size = s;
    exp_hdr.addr = a;
    exp_hdr_q.push_back(exp_hdr);
    exp_data_q.push_back((t == e_mem_wr) ? '0 : spread(loaded, n));
  endtask

  task automatic wait_idle();
    @(negedge clk);
    cmd_v = 1'b0;
    while (exp_hdr_q.size() != 0)
      @(posedge clk);
  endtask

  task automatic tag_init_test();
    wait (reset === 1'b0);
    @(posedge clk);
    while (cmd_ready !== 1'b1)
      @(posedge clk);
    if (i_cache.tag_cnt != tag_blocks_c)
      stop_run($sformatf("command port opened after %0d tag stores instead of %0d",
        i_cache.tag_cnt, tag_blocks_c));
    for (int i = 0; i < tag_blocks_c; i++)
      addr_check(i_cache.tag_log[6'(i)], addr_t'(i * 32), "tag store address");
  endtask

  // write then read every size at every aligned offset
  task automatic size_sweep_test();
    msg_size_e s;
    addr_t     a;
    for (int sz = 0; sz < 4; sz++)
    begin
      s = msg_size_e'(sz[1:0]);
      for (int off = 0; off < data_bytes_c; off += (1 << sz))
      begin
        a = addr_t'(64 + 8 * sz + off);
        drive_cmd(e_mem_wr, s, a, rand_bits(64));
        drive_cmd(e_mem_rd, s, a, '0);
        wait_idle();
      end
    end
  endtask

  task automatic back_pressure_test();
    @(negedge clk);
    resp_ready = 1'b0;
    for (int i = 0; i < hdr_fifo_depth_c; i++)
      drive_cmd(e_mem_rd, e_size_8, addr_t'(64 + 8 * i), '0);
    // a fifth read waits while the header queue is full
    @(negedge clk);
    cmd_addr = 32'h60;
    cmd_v = 1'b1;
    repeat (20)
    begin
      @(posedge clk);
      if (cmd_ready)
        stop_run("a fifth command was accepted while four responses were held back");
      if (cache_data_yumi !== 1'b0)
        stop_run("cache data was consumed while responses were held back");
    end
    @(negedge clk);
    cmd_v = 1'b0;
    resp_ready = 1'b1;
    wait_idle();
  endtask

  task automatic random_traffic_test();
    logic [63:0] r;
    msg_type_e   t;
    msg_size_e   s;
    addr_t       a;
    for (int k = 0; k < random_cmds_c; k++)
    begin
      r = rand_bits(1);
      t = msg_type_e'(r[0]);
      r = rand_bits(2);
      s = msg_size_e'(r[1:0]);
      r = rand_bits(8);
      a = addr_t'(r[7:0]) & ~((addr_t'(1) << s) - 1);
      drive_cmd(t, s, a, rand_bits(64));
    end
    wait_idle();
  endtask

  // cache stalls in roughly one cycle of four
  always @(negedge clk)
  begin
    logic b0;
    logic b1;
    b0 = stall_lfsr[0];
    stall_lfsr = lfsr_step(stall_lfsr);
    b1 = stall_lfsr[0];
    stall_lfsr = lfsr_step(stall_lfsr);
    cache_stall <= b0 & b1;
  end

  // responses must come back in command order
  always @(posedge clk)
  begin
    mem_hdr_s got_hdr;
    if (resp_v && resp_ready)
    begin
      got_hdr = '{msg_type: resp_type, size: resp_size, addr: resp_addr};
      if (exp_hdr_q.size() == 0)
        stop_run("a response arrived with no command outstanding");
      else
      begin
        if (cache_data_yumi !== 1'b1)
          stop_run("cache data was not consumed with its response");
        hdr_check(got_hdr, exp_hdr_q[0], "response header");
        data_check(resp_data, exp_data_q[0], "response data");
        void'(exp_hdr_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles_c)
      stop_run($sformatf("timeout: tests did not finish within %0d cycles", max_cycles_c));
  end

  initial
  begin
    cmd_type = e_mem_rd;
    cmd_size = e_size_1;
    cmd_addr = '0;
    cmd_data = '0;
    cmd_v = 1'b0;
    resp_ready = 1'b1;
    // same fill as the cache model
    for (int i = 0; i < 256; i++)
      ref_mem[8'(i)] = 8'(i * 29 + 7);
    tag_init_test();
    size_sweep_test();
    back_pressure_test();
    random_traffic_test();
    if (i_cache.tag_cnt == tag_blocks_c && exp_hdr_q.size() == 0)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
      stop_run("extra tag stores or missing responses at the end of the run");
  end

endmodule

`default_nettype wire

// File: vlog.f
mem_cache_pkg.sv
cache_req_if.sv
resp_hdr_if.sv
tag_init_seq.sv
cmd_decode.sv
resp_hdr_fifo.sv
resp_pack.sv
mem_to_cache.sv
tb_clock_gen.sv
tb_cache_model.sv
tb_mem_to_cache.sv
